/* logic/conv_pkg.sv */
package conv_pkg;

    // Layer geometry
    localparam int NUM_CHANNELS  = 8;
    localparam int KERNEL_TAPS   = 5;
    localparam int NUM_FILTERS   = 4;
    localparam int REQUANT_SHIFT = 8;
    localparam int ACT_MAX       = 127;

    localparam int SAMPLE_W = 8;
    localparam int CHAN_W   = KERNEL_TAPS * SAMPLE_W;  // One channel, all taps
    localparam int DOT_W    = 19;
    localparam int ACC_W    = 22;

    typedef logic [SAMPLE_W-1:0]              sample_t;
    typedef logic signed [SAMPLE_W-1:0]       weight_t;
    typedef logic [CHAN_W-1:0]                coef_t;         // Tap 0 in low byte
    typedef logic [CHAN_W-1:0]                chan_window_t;  // Tap 0 in low byte
    typedef logic [NUM_CHANNELS*CHAN_W-1:0]   window_t;       // Channel 0 in low bits
    typedef logic signed [DOT_W-1:0]          dot_t;
    typedef logic signed [ACC_W-1:0]          acc_t;
    typedef logic signed [SAMPLE_W-1:0]       act_t;
    typedef logic [$clog2(NUM_FILTERS)-1:0]   filter_idx_t;

    typedef enum logic {
        IDLE,
        ISSUE
    } ctrl_state_t;

    // Weights per filter and channel, listed tap 4 down to tap 0
    localparam coef_t FILTER_WEIGHTS [NUM_FILTERS][NUM_CHANNELS] = '{
        '{  // Filter 0
            {-8'sd34,  -8'sd9,   -8'sd55,  -8'sd13,  8'sd16},
            {-8'sd41,  8'sd40,   8'sd38,   8'sd4,    -8'sd42},
            {-8'sd1,   -8'sd18,  8'sd45,   -8'sd4,   -8'sd50},
            {8'sd19,   -8'sd23,  8'sd35,   -8'sd45,  8'sd22},
            {8'sd31,   8'sd47,   8'sd30,   8'sd26,   8'sd31},
            {-8'sd37,  -8'sd29,  -8'sd20,  -8'sd5,   -8'sd28},
            {8'sd53,   -8'sd1,   8'sd15,   -8'sd36,  8'sd28},
            {-8'sd20,  -8'sd28,  -8'sd13,  8'sd29,   -8'sd40}
        },
        '{  // Filter 1
            {-8'sd10,  8'sd43,   8'sd54,   -8'sd25,  8'sd41},
            {8'sd12,   8'sd4,    -8'sd12,  -8'sd16,  8'sd3},
            {-8'sd73,  8'sd40,   8'sd52,   8'sd24,   -8'sd35},
            {8'sd42,   -8'sd29,  -8'sd22,  8'sd4,    -8'sd4},
            {-8'sd37,  8'sd62,   8'sd9,    -8'sd42,  -8'sd12},
            {-8'sd4,   8'sd19,   8'sd27,   8'sd48,   -8'sd31},
            {-8'sd54,  -8'sd14,  -8'sd23,  -8'sd58,  -8'sd73},
            {8'sd39,   -8'sd53,  -8'sd14,  -8'sd45,  8'sd56}
        },
        '{  // Filter 2
            {-8'sd56,  8'sd7,    -8'sd22,  8'sd12,   -8'sd4},
            {8'sd9,    8'sd6,    8'sd26,   8'sd34,   8'sd17},
            {-8'sd53,  8'sd35,   8'sd67,   -8'sd56,  -8'sd10},
            {8'sd24,   -8'sd44,  8'sd59,   -8'sd61,  8'sd57},
            {-8'sd29,  8'sd30,   8'sd31,   -8'sd30,  8'sd0},
            {8'sd9,    8'sd4,    8'sd20,   8'sd37,   8'sd17},
            {8'sd52,   -8'sd27,  -8'sd24,  -8'sd32,  -8'sd14},
            {-8'sd24,  -8'sd48,  8'sd23,   -8'sd7,   8'sd14}
        },
        '{  // Filter 3
            {8'sd26,   -8'sd102, 8'sd40,   -8'sd64,  -8'sd28},
            {8'sd36,   8'sd7,    8'sd67,   8'sd10,   8'sd2},
            {-8'sd18,  8'sd9,    8'sd6,    -8'sd17,  8'sd70},
            {8'sd60,   -8'sd3,   -8'sd9,   8'sd17,   -8'sd48},
            {-8'sd40,  -8'sd41,  -8'sd28,  8'sd0,    -8'sd29},
            {8'sd0,    -8'sd38,  -8'sd71,  -8'sd72,  -8'sd111},
            {8'sd57,   -8'sd29,  8'sd49,   8'sd18,   -8'sd22},
            {8'sd2,    -8'sd15,  8'sd58,   -8'sd10,  -8'sd19}
        }
    };

endpackage

/* logic/channel_mac.sv */
`timescale 1ns/10ps

module channel_mac (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    input  conv_pkg::chan_window_t samples,
    input  conv_pkg::coef_t        coefs,
    output conv_pkg::dot_t         dot
);

    import conv_pkg::*;

    dot_t sum;

    // Five unsigned samples against five signed weights
    always_comb begin
        sample_t            smp;
        weight_t            wgt;
        logic signed [16:0] prod;
        sum = '0;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            smp  = samples[t*SAMPLE_W +: SAMPLE_W];
            wgt  = coefs[t*SAMPLE_W +: SAMPLE_W];
            prod = $signed({1'b0, smp}) * wgt;  // Zero-extended sample keeps it positive
            sum  = sum + dot_t'(prod);          // 5 x 32640 fits in 19 bits
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dot <= '0;
        end else if (advance) begin  // Holds along with the output stage
            dot <= sum;
        end
    end

endmodule

/* logic/requant_sat.sv */
`timescale 1ns/10ps

module requant_sat (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            issue_valid,
    input  conv_pkg::filter_idx_t                           issue_filter,
    input  logic [conv_pkg::NUM_CHANNELS*conv_pkg::DOT_W-1:0] dots,
    input  logic                                            out_ready,
    output logic                                            advance,
    output logic                                            out_valid,
    output conv_pkg::act_t                                  out_act,
    output conv_pkg::filter_idx_t                           out_filter
);

    import conv_pkg::*;

    logic        tag_valid;   // Matches the channel_mac registers
    filter_idx_t tag_filter;
    acc_t        acc;
    acc_t        shifted;
    act_t        sat;

    assign advance = !out_valid || out_ready;  // Output empty or leaving now

    always_comb begin
        dot_t d;
        acc = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            d   = dots[c*DOT_W +: DOT_W];
            acc = acc + acc_t'(d);
        end
        shifted = acc >>> REQUANT_SHIFT;
        if (shifted > ACT_MAX)
            sat = act_t'(ACT_MAX);
        else if (shifted < -ACT_MAX)
            sat = act_t'(-ACT_MAX);  // Symmetric clamp, -128 never appears
        else
            sat = shifted[SAMPLE_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_valid <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            tag_valid <= issue_valid;
            out_valid <= tag_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tag_filter <= issue_filter;
            out_act    <= sat;
            out_filter <= tag_filter;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_act) && $stable(out_filter));

    a_no_min_act: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_act != -8'sd128);

endmodule

/* logic/layer_ctrl.sv */
`timescale 1ns/10ps

module layer_ctrl (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             in_valid,
    input  conv_pkg::window_t                                in_window,
    input  logic                                             advance,
    output logic                                             in_ready,
    output logic                                             issue_valid,
    output conv_pkg::filter_idx_t                            issue_filter,
    output conv_pkg::window_t                                issue_window,
    output logic [conv_pkg::NUM_CHANNELS*conv_pkg::CHAN_W-1:0] issue_coefs
);

    import conv_pkg::*;

    ctrl_state_t state;
    filter_idx_t filter_cnt;
    window_t     window_q;

    assign in_ready     = (state == IDLE);
    assign issue_valid  = (state == ISSUE);
    assign issue_filter = filter_cnt;
    assign issue_window = window_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            filter_cnt <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (in_valid) begin
                        state      <= ISSUE;
                        filter_cnt <= '0;  // Always start at filter 0
                    end
                end
                ISSUE: begin
                    if (advance) begin  // Current filter taken by the MACs
                        if (filter_cnt == filter_idx_t'(NUM_FILTERS - 1))
                            state <= IDLE;
                        filter_cnt <= filter_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            window_q <= in_window;
    end

    // Weight lookup for the filter on issue
    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++)
            issue_coefs[c*CHAN_W +: CHAN_W] = FILTER_WEIGHTS[filter_cnt][c];
    end

    // No new window until every filter of this one has gone out
    a_busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready |=> !in_ready [*NUM_FILTERS]);

endmodule

/* logic/conv_layer.sv */
`timescale 1ns/10ps

module conv_layer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  conv_pkg::window_t     in_window,
    output logic                  in_ready,
    output logic                  out_valid,
    output conv_pkg::act_t        out_act,
    output conv_pkg::filter_idx_t out_filter,
    input  logic                  out_ready
);

    import conv_pkg::*;

    logic                           advance;
    logic                           issue_valid;
    filter_idx_t                    issue_filter;
    window_t                        issue_window;
    logic [NUM_CHANNELS*CHAN_W-1:0] issue_coefs;
    logic [NUM_CHANNELS*DOT_W-1:0]  dots;

    layer_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_window    (in_window),
        .advance      (advance),
        .in_ready     (in_ready),
        .issue_valid  (issue_valid),
        .issue_filter (issue_filter),
        .issue_window (issue_window),
        .issue_coefs  (issue_coefs)
    );

    // One MAC per channel, fed its slice of window and weights
    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
        channel_mac u_mac (
            .clk     (clk),
            .rst     (rst),
            .advance (advance),
            .samples (issue_window[c*CHAN_W +: CHAN_W]),
            .coefs   (issue_coefs[c*CHAN_W +: CHAN_W]),
            .dot     (dots[c*DOT_W +: DOT_W])
        );
    end

    requant_sat u_requant (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_filter (issue_filter),
        .dots         (dots),
        .out_ready    (out_ready),
        .advance      (advance),  // Sole stall source
        .out_valid    (out_valid),
        .out_act      (out_act),
        .out_filter   (out_filter)
    );

endmodule

/* tb/conv_checker.sv */
`timescale 1ns/10ps

module conv_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_ready,
    input  logic                  out_valid,
    input  conv_pkg::act_t        out_act,
    input  conv_pkg::filter_idx_t out_filter,
    input  logic                  out_ready,
    input  logic                  exp_push,
    input  conv_pkg::window_t     exp_window,
    output int                    value_errors,
    output int                    protocol_errors,
    output int                    results_seen,
    output int                    pending_results
);

    import conv_pkg::*;

    window_t     window_fifo[$];  // Accepted windows in arrival order
    int          cur_filter;      // Next filter expected from the head window
    bit          reset_checked;
    bit          stalled;
    act_t        held_act;
    filter_idx_t held_filter;

    // Dot products, channel sum, arithmetic shift, symmetric clamp
    function automatic int reference_act(input window_t w, input int f);
        int acc;
        int smp;
        int wgt;
        int shifted;
        acc = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                smp = int'(w[c*CHAN_W + t*SAMPLE_W +: SAMPLE_W]);  // Unsigned sample
                wgt = int'($signed(FILTER_WEIGHTS[f][c][t*SAMPLE_W +: SAMPLE_W]));
                acc = acc + smp * wgt;
            end
        end
        shifted = acc >>> REQUANT_SHIFT;
        if (shifted > ACT_MAX)
            return ACT_MAX;
        if (shifted < -ACT_MAX)
            return -ACT_MAX;
        return shifted;
    endfunction

    // Handshakes and outputs settle before the falling edge
    always @(negedge clk) begin
        int expected;
        if (rst) begin
            window_fifo.delete();
            cur_filter      = 0;
            reset_checked   = 1'b0;
            stalled         = 1'b0;
            value_errors    = 0;
            protocol_errors = 0;
            results_seen    = 0;
            pending_results = 0;
        end else begin
            if (!reset_checked) begin
                if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
                    $display("Error at %0t: after reset out_valid=%b in_ready=%b, expected 0 and 1",
                             $time, out_valid, in_ready);
                    protocol_errors++;
                end
                reset_checked = 1'b1;
            end
            if (exp_push)
                window_fifo.push_back(exp_window);  // Accepted at the coming edge
            if (stalled && (out_valid !== 1'b1 || out_act !== held_act ||
                            out_filter !== held_filter)) begin
                $display("Error at %0t: output changed while stalled", $time);
                protocol_errors++;
            end
            stalled     = out_valid && !out_ready;
            held_act    = out_act;
            held_filter = out_filter;
            if (out_valid && out_ready) begin
                if (window_fifo.size() == 0) begin
                    $display("Unexpected extra result at %0t with no window waiting for it",
                             $time);
                    protocol_errors++;
                end else begin
                    expected = reference_act(window_fifo[0], cur_filter);
                    if (int'(out_act) != expected || int'(out_filter) != cur_filter) begin
                        $display("Error at %0t: act %0d filter %0d, expected %0d filter %0d",
                                 $time, out_act, out_filter, expected, cur_filter);
                        value_errors++;
                    end
                    results_seen++;
                    if (cur_filter == NUM_FILTERS - 1) begin  // Window finished
                        cur_filter = 0;
                        void'(window_fifo.pop_front());
                    end else begin
                        cur_filter++;
                    end
                end
            end
            pending_results = window_fifo.size() * NUM_FILTERS - cur_filter;
        end
    end

endmodule

/* tb/tb_conv_layer.sv */
`timescale 1ns/10ps

module tb_conv_layer;

    import conv_pkg::*;

    localparam int RESET_CYCLES  = 5;
    localparam int SAT_WINDOWS   = 2 * NUM_FILTERS;
    localparam int RAND_WINDOWS  = 200;
    localparam int TOTAL_WINDOWS = 1 + SAT_WINDOWS + RAND_WINDOWS;
    localparam int CYCLE_LIMIT   = 20 * TOTAL_WINDOWS + RESET_CYCLES;

    logic        clk;
    logic        rst;
    logic        in_valid;
    window_t     in_window;
    logic        in_ready;
    logic        out_valid;
    act_t        out_act;
    filter_idx_t out_filter;
    logic        out_ready;
    logic        exp_push;
    window_t     exp_window;
    bit          random_ready;  // Back-pressure on the output when set
    int          cycle_count;
    int          value_errors;
    int          protocol_errors;
    int          results_seen;
    int          pending_results;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    conv_layer UUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_window  (in_window),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_act    (out_act),
        .out_filter (out_filter),
        .out_ready  (out_ready)
    );

    conv_checker checker_inst (
        .clk             (clk),
        .rst             (rst),
        .in_ready        (in_ready),
        .out_valid       (out_valid),
        .out_act         (out_act),
        .out_filter      (out_filter),
        .out_ready       (out_ready),
        .exp_push        (exp_push),
        .exp_window      (exp_window),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .results_seen    (results_seen),
        .pending_results (pending_results)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
        exp_push  = 1'b0;
        out_ready = random_ready ? ($urandom % 4 != 0) : 1'b1;  // Ready about 3 cycles in 4
    endtask

    // Holds in_valid until the controller takes the window
    task automatic send_window(input window_t w);
        bit accepted;
        accepted  = 1'b0;
        in_valid  = 1'b1;
        in_window = w;
        while (!accepted) begin
            if (in_ready) begin  // Stable until the next edge
                exp_push   = 1'b1;
                exp_window = w;
                accepted   = 1'b1;
            end
            next_cycle();
        end
    endtask

    function automatic window_t random_window();
        window_t w;
        for (int i = 0; i < $bits(window_t) / 32; i++)
            w[i*32 +: 32] = $urandom;
        return w;
    endfunction

    // Full-scale samples on one sign of the filter's weights drive it to the clamp
    function automatic window_t saturating_window(input int f, input bit positive);
        window_t w;
        weight_t wt;
        w = '0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                wt = FILTER_WEIGHTS[f][c][t*SAMPLE_W +: SAMPLE_W];
                if ((positive && wt > 0) || (!positive && wt < 0))
                    w[c*CHAN_W + t*SAMPLE_W +: SAMPLE_W] = 8'hff;
            end
        end
        return w;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d of %0d results seen",
                     cycle_count, results_seen, NUM_FILTERS * TOTAL_WINDOWS);
            $display("%0d expected results never came out", pending_results);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hfdfe2bcf));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_window    = '0;
        out_ready    = 1'b1;
        exp_push     = 1'b0;
        exp_window   = '0;
        random_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        send_window('0);
        for (int f = 0; f < NUM_FILTERS; f++) begin
            send_window(saturating_window(f, 1'b1));
            send_window(saturating_window(f, 1'b0));
        end
        random_ready = 1'b1;
        for (int i = 0; i < RAND_WINDOWS; i++)
            send_window(random_window());  // in_valid stays high between windows
        in_valid = 1'b0;

        while (results_seen < NUM_FILTERS * TOTAL_WINDOWS)
            next_cycle();
        random_ready = 1'b0;
        repeat (10) next_cycle();  // Room for any stray extra result

        $display("Results %0d of %0d, value errors %0d, protocol errors %0d",
                 results_seen, NUM_FILTERS * TOTAL_WINDOWS, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/conv_pkg.sv
logic/channel_mac.sv
logic/requant_sat.sv
logic/layer_ctrl.sv
logic/conv_layer.sv
tb/conv_checker.sv
tb/tb_conv_layer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_conv_layer
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
